/* filelist.f */
hdl/axi2axil_pkg.sv
hdl/burst_addr_gen.sv
hdl/axi2axil_write.sv
hdl/axi2axil_read.sv
hdl/axi2axil_bridge.sv
bench/axil_target_model.sv
bench/tb_axi2axil.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_axi2axil \
  -f filelist.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_axi2axil)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST OK"; then
  exit 0
fi
exit 1

/* bench/tb_axi2axil.sv */
`timescale 1ns/100ps

module tb_axi2axil import axi2axil_pkg::*; ();

  localparam int         timeout_cycles = 200;
  // awready, arready, bvalid, rvalid, Lite awvalid, wvalid, arvalid
  localparam logic [6:0] reset_ok       = 7'b110_0000;

  logic        clk = 1'b0;
  logic        rst = 1'b1;

  // AXI4 side driven by the stimulus tasks
  logic [11:0] s_awaddr  = '0;
  logic [3:0]  s_awid    = '0;
  burst_len_t  s_awlen   = '0;
  burst_size_t s_awsize  = '0;
  burst_type_t s_awburst = BURST_INCR;
  prot_t       s_awprot  = '0;
  logic        s_awvalid = 1'b0;
  logic        s_awready;
  logic [31:0] s_wdata   = '0;
  logic [3:0]  s_wstrb   = '0;
  logic        s_wvalid  = 1'b0;
  logic        s_wready;
  logic [3:0]  s_bid;
  resp_t       s_bresp;
  logic        s_bvalid;
  logic        s_bready  = 1'b0;
  logic [11:0] s_araddr  = '0;
  logic [3:0]  s_arid    = '0;
  burst_len_t  s_arlen   = '0;
  burst_size_t s_arsize  = '0;
  burst_type_t s_arburst = BURST_INCR;
  prot_t       s_arprot  = '0;
  logic        s_arvalid = 1'b0;
  logic        s_arready;
  logic [31:0] s_rdata;
  resp_t       s_rresp;
  logic [3:0]  s_rid;
  logic        s_rlast;
  logic        s_rvalid;
  logic        s_rready  = 1'b0;

  // AXI4-Lite side between DUT and target
  logic [11:0] m_awaddr;
  prot_t       m_awprot;
  logic        m_awvalid;
  logic        m_awready;
  logic [31:0] m_wdata;
  logic [3:0]  m_wstrb;
  logic        m_wvalid;
  logic        m_wready;
  resp_t       m_bresp;
  logic        m_bvalid;
  logic        m_bready;
  logic [11:0] m_araddr;
  prot_t       m_arprot;
  logic        m_arvalid;
  logic        m_arready;
  logic [31:0] m_rdata;
  resp_t       m_rresp;
  logic        m_rvalid;
  logic        m_rready;

  // Expected values for the running burst
  logic [11:0] exp_waddr [0:255];
  logic [31:0] exp_wdata [0:255];
  logic [11:0] exp_raddr [0:255];
  logic [31:0] exp_rdata [0:255];
  resp_t       exp_rresp [0:255];
  logic [3:0]  exp_bid;
  logic [3:0]  exp_rid;
  resp_t       exp_bresp;
  prot_t       exp_prot;
  burst_len_t  exp_rlen;
  // Reference memory by word address
  logic [31:0] ref_mem [0:511];

  // Beat position inside the running bursts
  burst_len_t  wbeat;
  burst_len_t  rbeat;
  logic [11:0] exp_aw;
  logic [31:0] exp_wd;
  logic [11:0] exp_ar;
  logic [31:0] exp_rd;
  resp_t       exp_rr;
  logic        exp_rl;
  logic [6:0]  reset_view;

  string       test_name = "none";
  int          tests = 0;
  int          errors = 0;
  int          errors_at_start = 0;
  logic        stall = 1'b0;
  integer      seed = 32'h724b;

  always #2 clk = ~clk;

  axi2axil_bridge #(
    .addr_width (12),
    .data_width (32),
    .id_width   (4)
  ) dut_i (.*);

  axil_target_model #(
    .addr_width (12),
    .data_width (32)
  ) target_i (
    .clk     (clk),
    .rst     (rst),
    .awaddr  (m_awaddr),
    .awvalid (m_awvalid),
    .awready (m_awready),
    .wdata   (m_wdata),
    .wstrb   (m_wstrb),
    .wvalid  (m_wvalid),
    .wready  (m_wready),
    .bresp   (m_bresp),
    .bvalid  (m_bvalid),
    .bready  (m_bready),
    .araddr  (m_araddr),
    .arvalid (m_arvalid),
    .arready (m_arready),
    .rdata   (m_rdata),
    .rresp   (m_rresp),
    .rvalid  (m_rvalid),
    .rready  (m_rready)
  );

  // Lite AW count restarts on the AXI4 B and the R count on rlast
  always_ff @(posedge clk) begin
    if (rst) begin
      wbeat <= '0;
      rbeat <= '0;
    end else begin
      if (s_bvalid && s_bready) wbeat <= '0;
      else if (m_awvalid && m_awready) wbeat <= wbeat + 8'd1;
      if (s_rvalid && s_rready) rbeat <= s_rlast ? 8'd0 : rbeat + 8'd1;
    end
  end

  assign exp_aw     = exp_waddr[wbeat];
  // Lite W follows the AW of its beat, so the count is already one ahead
  assign exp_wd     = exp_wdata[wbeat - 8'd1];
  assign exp_ar     = exp_raddr[rbeat];
  assign exp_rd     = exp_rdata[rbeat];
  assign exp_rr     = exp_rresp[rbeat];
  assign exp_rl     = (rbeat == exp_rlen);
  assign reset_view = {s_awready, s_arready, s_bvalid, s_rvalid, m_awvalid, m_wvalid, m_arvalid};

  task automatic report_mismatch(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("CHECK FAILED %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
    errors++;
  endtask

  // --------------------------------------------------------------------------
  // Checks on every transfer
  // --------------------------------------------------------------------------

  reset_state_a: assert property (@(posedge clk) $fell(rst) |-> reset_view == reset_ok)
    else report_mismatch("reset outputs", 32'(reset_ok), 32'($sampled(reset_view)));

  lite_aw_addr_a: assert property (@(posedge clk) disable iff (rst)
    m_awvalid && m_awready |-> m_awaddr == exp_aw)
    else report_mismatch("lite awaddr", 32'($sampled(exp_aw)), 32'($sampled(m_awaddr)));

  lite_aw_prot_a: assert property (@(posedge clk) disable iff (rst)
    m_awvalid && m_awready |-> m_awprot == exp_prot)
    else report_mismatch("lite awprot", 32'($sampled(exp_prot)), 32'($sampled(m_awprot)));

  lite_w_data_a: assert property (@(posedge clk) disable iff (rst)
    m_wvalid && m_wready |-> m_wdata == exp_wd)
    else report_mismatch("lite wdata", $sampled(exp_wd), $sampled(m_wdata));

  lite_w_strb_a: assert property (@(posedge clk) disable iff (rst)
    m_wvalid && m_wready |-> m_wstrb == 4'hf)
    else report_mismatch("lite wstrb", 32'hf, 32'($sampled(m_wstrb)));

  lite_ar_addr_a: assert property (@(posedge clk) disable iff (rst)
    m_arvalid && m_arready |-> m_araddr == exp_ar)
    else report_mismatch("lite araddr", 32'($sampled(exp_ar)), 32'($sampled(m_araddr)));

  lite_ar_prot_a: assert property (@(posedge clk) disable iff (rst)
    m_arvalid && m_arready |-> m_arprot == exp_prot)
    else report_mismatch("lite arprot", 32'($sampled(exp_prot)), 32'($sampled(m_arprot)));

  bid_a: assert property (@(posedge clk) disable iff (rst)
    s_bvalid && s_bready |-> s_bid == exp_bid)
    else report_mismatch("bid", 32'($sampled(exp_bid)), 32'($sampled(s_bid)));

  bresp_a: assert property (@(posedge clk) disable iff (rst)
    s_bvalid && s_bready |-> s_bresp == exp_bresp)
    else report_mismatch("bresp", 32'($sampled(exp_bresp)), 32'($sampled(s_bresp)));

  rdata_a: assert property (@(posedge clk) disable iff (rst)
    s_rvalid && s_rready |-> s_rdata == exp_rd)
    else report_mismatch("rdata", $sampled(exp_rd), $sampled(s_rdata));

  rresp_a: assert property (@(posedge clk) disable iff (rst)
    s_rvalid && s_rready |-> s_rresp == exp_rr)
    else report_mismatch("rresp", 32'($sampled(exp_rr)), 32'($sampled(s_rresp)));

  rid_a: assert property (@(posedge clk) disable iff (rst)
    s_rvalid && s_rready |-> s_rid == exp_rid)
    else report_mismatch("rid", 32'($sampled(exp_rid)), 32'($sampled(s_rid)));

  rlast_a: assert property (@(posedge clk) disable iff (rst)
    s_rvalid && s_rready |-> s_rlast == exp_rl)
    else report_mismatch("rlast", 32'($sampled(exp_rl)), 32'($sampled(s_rlast)));

  // --------------------------------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------------------------------

  // Stalls roughly one cycle in four when enabled
  function automatic logic pick_ready();
    if (!stall) return 1'b1;
    return ($random(seed) & 3) != 0;
  endfunction

  // FIXED stays on the base and INCR steps by four bytes
  function automatic logic [11:0] expected_addr(input logic [11:0] base,
                                                input burst_type_t kind, input int beat);
    if (kind == BURST_FIXED) return base;
    return base + 12'(beat * 4);
  endfunction

  task automatic stop_on_timeout(input string what);
    $display("Timeout in test %s while waiting for %s", test_name, what);
    $display("TEST FAILED");
    $finish;
  endtask

  task automatic write_burst(input logic [11:0] addr, input burst_len_t len,
                             input burst_type_t kind, input logic [3:0] id,
                             input logic [31:0] data0);
    logic [11:0] a;
    int          i;
    int          n;
    // Expectations change at the falling edge
    @(negedge clk);
    exp_bid   = id;
    exp_prot  = id[2:0];
    exp_bresp = RESP_OKAY;
    for (i = 0; i <= int'(len); i++) begin
      a = expected_addr(addr, kind, i);
      exp_waddr[i] = a;
      exp_wdata[i] = data0 + 32'(i) * 32'h0101_0101;
      if (a[11]) exp_bresp = RESP_SLVERR;
      else ref_mem[a[10:2]] = exp_wdata[i];
    end
    @(posedge clk);
    s_awaddr  <= addr;
    s_awid    <= id;
    s_awlen   <= len;
    s_awsize  <= 3'd2;
    s_awburst <= kind;
    s_awprot  <= id[2:0];
    s_awvalid <= 1'b1;
    for (n = 0; n < timeout_cycles; n++) begin
      @(negedge clk);
      if (s_awready) break;
    end
    if (n == timeout_cycles) stop_on_timeout("awready");
    @(posedge clk);
    s_awvalid <= 1'b0;
    // Bridge counts the beats itself since W has no wlast
    for (i = 0; i <= int'(len); i++) begin
      s_wdata  <= data0 + 32'(i) * 32'h0101_0101;
      s_wstrb  <= 4'hf;
      s_wvalid <= 1'b1;
      for (n = 0; n < timeout_cycles; n++) begin
        @(negedge clk);
        if (s_wready) break;
      end
      if (n == timeout_cycles) stop_on_timeout("wready");
      @(posedge clk);
    end
    s_wvalid <= 1'b0;
    s_bready <= pick_ready();
    for (n = 0; n < timeout_cycles; n++) begin
      @(negedge clk);
      if (s_bvalid && s_bready) break;
      @(posedge clk);
      s_bready <= pick_ready();
    end
    if (n == timeout_cycles) stop_on_timeout("write response");
    @(posedge clk);
    s_bready <= 1'b0;
  endtask

  task automatic read_burst(input logic [11:0] addr, input burst_len_t len,
                            input burst_type_t kind, input logic [3:0] id);
    logic [11:0] a;
    int          i;
    int          n;
    @(negedge clk);
    exp_rid  = id;
    exp_rlen = len;
    exp_prot = id[2:0];
    for (i = 0; i <= int'(len); i++) begin
      a = expected_addr(addr, kind, i);
      exp_raddr[i] = a;
      exp_rdata[i] = a[11] ? 32'h0 : ref_mem[a[10:2]];
      exp_rresp[i] = a[11] ? RESP_SLVERR : RESP_OKAY;
    end
    @(posedge clk);
    s_araddr  <= addr;
    s_arid    <= id;
    s_arlen   <= len;
    s_arsize  <= 3'd2;
    s_arburst <= kind;
    s_arprot  <= id[2:0];
    s_arvalid <= 1'b1;
    for (n = 0; n < timeout_cycles; n++) begin
      @(negedge clk);
      if (s_arready) break;
    end
    if (n == timeout_cycles) stop_on_timeout("arready");
    @(posedge clk);
    s_arvalid <= 1'b0;
    s_rready  <= pick_ready();
    // Only the last beat ends the wait
    for (n = 0; n < timeout_cycles; n++) begin
      @(negedge clk);
      if (s_rvalid && s_rready && s_rlast) break;
      @(posedge clk);
      s_rready <= pick_ready();
    end
    if (n == timeout_cycles) stop_on_timeout("rlast");
    @(posedge clk);
    s_rready <= 1'b0;
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = errors;
  endtask

  task automatic finish_test();
    tests++;
    $display("%s: %s, %0d failed checks", test_name,
             (errors == errors_at_start) ? "passed" : "failed", errors - errors_at_start);
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------

  initial begin
    start_test("reset");
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    repeat (3) @(posedge clk);
    finish_test();

    start_test("single beat");
    write_burst(12'h010, 8'd0, BURST_INCR, 4'h3, 32'ha5a5_0001);
    read_burst(12'h010, 8'd0, BURST_INCR, 4'h5);
    finish_test();

    start_test("incr burst");
    write_burst(12'h040, 8'd3, BURST_INCR, 4'h1, 32'h1111_0000);
    read_burst(12'h040, 8'd3, BURST_INCR, 4'h2);
    finish_test();

    // Third word is the one left in memory
    start_test("fixed burst");
    write_burst(12'h080, 8'd2, BURST_FIXED, 4'h6, 32'h2222_0000);
    read_burst(12'h080, 8'd0, BURST_INCR, 4'h7);
    finish_test();

    // Crosses into the error region halfway
    start_test("error merge");
    write_burst(12'h7f8, 8'd3, BURST_INCR, 4'h9, 32'h4444_0000);
    read_burst(12'h7f8, 8'd3, BURST_INCR, 4'ha);
    finish_test();

    start_test("back-pressure");
    stall = 1'b1;
    write_burst(12'h040, 8'd3, BURST_INCR, 4'hb, 32'h3c3c_0000);
    read_burst(12'h040, 8'd3, BURST_INCR, 4'hc);
    write_burst(12'h7f8, 8'd3, BURST_INCR, 4'hd, 32'h5a5a_0000);
    read_burst(12'h7f8, 8'd3, BURST_INCR, 4'he);
    finish_test();

    $display("%0d tests run, %0d failed checks", tests, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* bench/axil_target_model.sv */
`timescale 1ns/100ps

module axil_target_model import axi2axil_pkg::*; #(
  parameter int addr_width = 12,
  parameter int data_width = 32,
  parameter int seed_init  = 32'h724b
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [addr_width-1:0]   awaddr,
  input  logic                    awvalid,
  output logic                    awready,
  input  logic [data_width-1:0]   wdata,
  input  logic [data_width/8-1:0] wstrb,
  input  logic                    wvalid,
  output logic                    wready,
  output resp_t                   bresp,
  output logic                    bvalid,
  input  logic                    bready,
  input  logic [addr_width-1:0]   araddr,
  input  logic                    arvalid,
  output logic                    arready,
  output logic [data_width-1:0]   rdata,
  output resp_t                   rresp,
  output logic                    rvalid,
  input  logic                    rready
);

  // 256 words, indexed by the word address bits 9:2
  logic [data_width-1:0] mem [0:255];
  // Write address waits here for its data
  logic [addr_width-1:0] waddr_q;
  logic                  waddr_full;
  // One random enable per ready, redrawn every cycle
  logic [2:0]            go;
  integer                seed = seed_init;

  always @(posedge clk) begin
    go <= 3'($random(seed));
  end

  // Ready only when the matching slot is free
  assign awready = go[0] && !waddr_full && !bvalid;
  assign wready  = go[1] && waddr_full;
  assign arready = go[2] && !rvalid;

  // --------------------------------------------------------------------------
  // Write channel, bit 11 of the address marks the error region
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      waddr_full <= 1'b0;
      bvalid     <= 1'b0;
    end else begin
      if (awvalid && awready) begin
        waddr_q    <= awaddr;
        waddr_full <= 1'b1;
      end
      if (wvalid && wready) begin
        waddr_full <= 1'b0;
        bvalid     <= 1'b1;
        bresp      <= waddr_q[11] ? RESP_SLVERR : RESP_OKAY;
      end else if (bvalid && bready) begin
        bvalid <= 1'b0;
      end
    end
  end

  // Byte lanes follow the strobes, error region stays untouched
  always_ff @(posedge clk) begin
    if (wvalid && wready && !waddr_q[11]) begin
      for (int b = 0; b < data_width/8; b++) begin
        if (wstrb[b]) mem[waddr_q[9:2]][8*b +: 8] <= wdata[8*b +: 8];
      end
    end
  end

  // Read channel, error region reads as zero
  always_ff @(posedge clk) begin
    if (rst) begin
      rvalid <= 1'b0;
    end else if (arvalid && arready) begin
      rvalid <= 1'b1;
      rdata  <= araddr[11] ? '0 : mem[araddr[9:2]];
      rresp  <= araddr[11] ? RESP_SLVERR : RESP_OKAY;
    end else if (rvalid && rready) begin
      rvalid <= 1'b0;
    end
  end

endmodule

/* hdl/axi2axil_bridge.sv */
`timescale 1ns/100ps

module axi2axil_bridge import axi2axil_pkg::*; #(
  parameter int addr_width = 12,
  parameter int data_width = 32,
  parameter int id_width   = 4
) (
  input  logic                    clk,
  input  logic                    rst,

  // --------------------------------------------------------------------------
  // AXI4 subordinate port
  // --------------------------------------------------------------------------
  input  logic [addr_width-1:0]   s_awaddr,
  input  logic [id_width-1:0]     s_awid,
  input  burst_len_t              s_awlen,
  input  burst_size_t             s_awsize,
  input  burst_type_t             s_awburst,
  input  prot_t                   s_awprot,
  input  logic                    s_awvalid,
  output logic                    s_awready,
  input  logic [data_width-1:0]   s_wdata,
  input  logic [data_width/8-1:0] s_wstrb,
  input  logic                    s_wvalid,
  output logic                    s_wready,
  output logic [id_width-1:0]     s_bid,
  output resp_t                   s_bresp,
  output logic                    s_bvalid,
  input  logic                    s_bready,
  input  logic [addr_width-1:0]   s_araddr,
  input  logic [id_width-1:0]     s_arid,
  input  burst_len_t              s_arlen,
  input  burst_size_t             s_arsize,
  input  burst_type_t             s_arburst,
  input  prot_t                   s_arprot,
  input  logic                    s_arvalid,
  output logic                    s_arready,
  output logic [data_width-1:0]   s_rdata,
  output resp_t                   s_rresp,
  output logic [id_width-1:0]     s_rid,
  output logic                    s_rlast,
  output logic                    s_rvalid,
  input  logic                    s_rready,

  // --------------------------------------------------------------------------
  // AXI4-Lite manager port
  // --------------------------------------------------------------------------
  output logic [addr_width-1:0]   m_awaddr,
  output prot_t                   m_awprot,
  output logic                    m_awvalid,
  input  logic                    m_awready,
  output logic [data_width-1:0]   m_wdata,
  output logic [data_width/8-1:0] m_wstrb,
  output logic                    m_wvalid,
  input  logic                    m_wready,
  input  resp_t                   m_bresp,
  input  logic                    m_bvalid,
  output logic                    m_bready,
  output logic [addr_width-1:0]   m_araddr,
  output prot_t                   m_arprot,
  output logic                    m_arvalid,
  input  logic                    m_arready,
  input  logic [data_width-1:0]   m_rdata,
  input  resp_t                   m_rresp,
  input  logic                    m_rvalid,
  output logic                    m_rready
);

  // Write path, runs independently of reads
  axi2axil_write #(
    .addr_width (addr_width),
    .data_width (data_width),
    .id_width   (id_width)
  ) write_i (
    .clk       (clk),
    .rst       (rst),
    .awaddr    (s_awaddr),
    .awid      (s_awid),
    .awlen     (s_awlen),
    .awsize    (s_awsize),
    .awburst   (s_awburst),
    .awprot    (s_awprot),
    .awvalid   (s_awvalid),
    .awready   (s_awready),
    .wdata     (s_wdata),
    .wstrb     (s_wstrb),
    .wvalid    (s_wvalid),
    .wready    (s_wready),
    .bid       (s_bid),
    .bresp     (s_bresp),
    .bvalid    (s_bvalid),
    .bready    (s_bready),
    .m_awaddr  (m_awaddr),
    .m_awprot  (m_awprot),
    .m_awvalid (m_awvalid),
    .m_awready (m_awready),
    .m_wdata   (m_wdata),
    .m_wstrb   (m_wstrb),
    .m_wvalid  (m_wvalid),
    .m_wready  (m_wready),
    .m_bresp   (m_bresp),
    .m_bvalid  (m_bvalid),
    .m_bready  (m_bready)
  );

  // Read path
  axi2axil_read #(
    .addr_width (addr_width),
    .data_width (data_width),
    .id_width   (id_width)
  ) read_i (
    .clk       (clk),
    .rst       (rst),
    .araddr    (s_araddr),
    .arid      (s_arid),
    .arlen     (s_arlen),
    .arsize    (s_arsize),
    .arburst   (s_arburst),
    .arprot    (s_arprot),
    .arvalid   (s_arvalid),
    .arready   (s_arready),
    .rdata     (s_rdata),
    .rresp     (s_rresp),
    .rid       (s_rid),
    .rlast     (s_rlast),
    .rvalid    (s_rvalid),
    .rready    (s_rready),
    .m_araddr  (m_araddr),
    .m_arprot  (m_arprot),
    .m_arvalid (m_arvalid),
    .m_arready (m_arready),
    .m_rdata   (m_rdata),
    .m_rresp   (m_rresp),
    .m_rvalid  (m_rvalid),
    .m_rready  (m_rready)
  );

endmodule

/* hdl/axi2axil_read.sv */
`timescale 1ns/100ps

module axi2axil_read import axi2axil_pkg::*; #(
  parameter int addr_width = 12,
  parameter int data_width = 32,
  parameter int id_width   = 4
) (
  input  logic                  clk,
  input  logic                  rst,

  // AXI4 read side
  input  logic [addr_width-1:0] araddr,
  input  logic [id_width-1:0]   arid,
  input  burst_len_t            arlen,
  input  burst_size_t           arsize,
  input  burst_type_t           arburst,
  input  prot_t                 arprot,
  input  logic                  arvalid,
  output logic                  arready,
  output logic [data_width-1:0] rdata,
  output resp_t                 rresp,
  output logic [id_width-1:0]   rid,
  output logic                  rlast,
  output logic                  rvalid,
  input  logic                  rready,

  // AXI4-Lite read side
  output logic [addr_width-1:0] m_araddr,
  output prot_t                 m_arprot,
  output logic                  m_arvalid,
  input  logic                  m_arready,
  input  logic [data_width-1:0] m_rdata,
  input  resp_t                 m_rresp,
  input  logic                  m_rvalid,
  output logic                  m_rready
);

  read_state_t           state;
  read_state_t           state_next;

  logic [id_width-1:0]   id_q;
  prot_t                 prot_q;

  logic                  ar_fire;
  logic                  r_fire;
  logic                  last_beat;
  logic [addr_width-1:0] beat_addr;

  assign ar_fire = arvalid && arready;
  // AXI4 and Lite R move together
  assign r_fire  = rvalid && rready;

  burst_addr_gen #(
    .addr_width (addr_width)
  ) addr_gen_i (
    .clk       (clk),
    .rst       (rst),
    .load      (ar_fire),
    .base_addr (araddr),
    .size      (arsize),
    .burst     (arburst),
    .len       (arlen),
    .advance   (r_fire),
    .beat_addr (beat_addr),
    .last_beat (last_beat)
  );

  always_ff @(posedge clk) begin
    if (ar_fire) begin
      id_q   <= arid;
      prot_q <= arprot;
    end
  end

  // --------------------------------------------------------------------------
  // Sequencer FSM
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= R_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      R_IDLE: if (ar_fire) state_next = R_ADDR;
      R_ADDR: if (m_arready) state_next = R_DATA;
      R_DATA: begin
        if (r_fire) begin
          state_next = last_beat ? R_IDLE : R_ADDR;
        end
      end
      default: state_next = R_IDLE;
    endcase
  end

  assign arready = (state == R_IDLE);

  // Each Lite response goes out as its own AXI4 beat
  assign rvalid = (state == R_DATA) && m_rvalid;
  assign rdata  = m_rdata;
  assign rresp  = m_rresp;
  assign rid    = id_q;
  assign rlast  = rvalid && last_beat;

  assign m_araddr  = beat_addr;
  assign m_arprot  = prot_q;
  assign m_arvalid = (state == R_ADDR);
  assign m_rready  = (state == R_DATA) && rready;

  rlast_needs_rvalid_a: assert property (@(posedge clk) disable iff (rst)
    rlast |-> rvalid);

endmodule

/* hdl/axi2axil_write.sv */
`timescale 1ns/100ps

module axi2axil_write import axi2axil_pkg::*; #(
  parameter int addr_width = 12,
  parameter int data_width = 32,
  parameter int id_width   = 4
) (
  input  logic                      clk,
  input  logic                      rst,

  // AXI4 write side
  input  logic [addr_width-1:0]     awaddr,
  input  logic [id_width-1:0]       awid,
  input  burst_len_t                awlen,
  input  burst_size_t               awsize,
  input  burst_type_t               awburst,
  input  prot_t                     awprot,
  input  logic                      awvalid,
  output logic                      awready,
  input  logic [data_width-1:0]     wdata,
  input  logic [data_width/8-1:0]   wstrb,
  input  logic                      wvalid,
  output logic                      wready,
  output logic [id_width-1:0]       bid,
  output resp_t                     bresp,
  output logic                      bvalid,
  input  logic                      bready,

  // AXI4-Lite write side
  output logic [addr_width-1:0]     m_awaddr,
  output prot_t                     m_awprot,
  output logic                      m_awvalid,
  input  logic                      m_awready,
  output logic [data_width-1:0]     m_wdata,
  output logic [data_width/8-1:0]   m_wstrb,
  output logic                      m_wvalid,
  input  logic                      m_wready,
  input  resp_t                     m_bresp,
  input  logic                      m_bvalid,
  output logic                      m_bready
);

  write_state_t          state;
  write_state_t          state_next;

  // Burst context kept for the whole burst
  logic [id_width-1:0]   id_q;
  prot_t                 prot_q;
  // Worst response seen so far
  resp_t                 resp_q;

  logic                  aw_fire;
  logic                  lite_b_fire;
  logic                  last_beat;
  logic [addr_width-1:0] beat_addr;

  assign aw_fire     = awvalid && awready;
  assign lite_b_fire = m_bvalid && m_bready;

  // --------------------------------------------------------------------------
  // Beat address
  // --------------------------------------------------------------------------

  burst_addr_gen #(
    .addr_width (addr_width)
  ) addr_gen_i (
    .clk       (clk),
    .rst       (rst),
    .load      (aw_fire),
    .base_addr (awaddr),
    .size      (awsize),
    .burst     (awburst),
    .len       (awlen),
    .advance   (lite_b_fire),
    .beat_addr (beat_addr),
    .last_beat (last_beat)
  );

  // --------------------------------------------------------------------------
  // Context and response merge
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (aw_fire) begin
      id_q   <= awid;
      prot_q <= awprot;
      resp_q <= RESP_OKAY;
    end else if (lite_b_fire && (m_bresp > resp_q)) begin
      // Keep the more severe code
      resp_q <= m_bresp;
    end
  end

  // --------------------------------------------------------------------------
  // Sequencer FSM
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= W_IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      W_IDLE: if (aw_fire) state_next = W_ADDR;
      W_ADDR: if (m_awready) state_next = W_DATA;
      // Both sides move in the same cycle
      W_DATA: if (wvalid && m_wready) state_next = W_RESP;
      W_RESP: begin
        if (lite_b_fire) begin
          state_next = last_beat ? W_DONE : W_ADDR;
        end
      end
      W_DONE: if (bready) state_next = W_IDLE;
      default: state_next = W_IDLE;
    endcase
  end

  // AXI4 side
  assign awready = (state == W_IDLE);
  assign wready  = (state == W_DATA) && m_wready;
  assign bvalid  = (state == W_DONE);
  assign bid     = id_q;
  assign bresp   = resp_q;

  // Lite side, W data is a straight pass of the AXI4 beat
  assign m_awaddr  = beat_addr;
  assign m_awprot  = prot_q;
  assign m_awvalid = (state == W_ADDR);
  assign m_wdata   = wdata;
  assign m_wstrb   = wstrb;
  assign m_wvalid  = (state == W_DATA) && wvalid;
  assign m_bready  = (state == W_RESP);

  // Merged response is held until taken
  bvalid_hold_a: assert property (@(posedge clk) disable iff (rst)
    bvalid && !bready |=> bvalid && $stable(bresp) && $stable(bid));

endmodule

/* hdl/burst_addr_gen.sv */
`timescale 1ns/100ps

module burst_addr_gen import axi2axil_pkg::*; #(
  parameter int addr_width = 12
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  load,
  input  logic [addr_width-1:0] base_addr,
  input  burst_size_t           size,
  input  burst_type_t           burst,
  input  burst_len_t            len,
  input  logic                  advance,
  output logic [addr_width-1:0] beat_addr,
  output logic                  last_beat
);

  // Burst context, captured on load
  logic [addr_width-1:0] base_q;
  burst_size_t           size_q;
  burst_type_t           burst_q;
  burst_len_t            len_q;
  // Index of the current beat
  burst_len_t            count;
  // Set once the final beat has been advanced past
  logic                  spent;

  always_ff @(posedge clk) begin
    if (load) begin
      base_q  <= base_addr;
      size_q  <= size;
      burst_q <= burst;
      len_q   <= len;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
      spent <= 1'b0;
    end else if (load) begin
      count <= '0;
      spent <= 1'b0;
    end else if (advance) begin
      count <= count + 8'd1;
      spent <= last_beat;
    end
  end

  // FIXED stays on the base, anything else steps by the beat size
  always_comb begin
    if (burst_q == BURST_FIXED) begin
      beat_addr = base_q;
    end else begin
      beat_addr = base_q + (addr_width'(count) << size_q);
    end
  end

  assign last_beat = (count == len_q);

  // Sequencer must reload before stepping a finished burst again
  advance_after_last_a: assert property (@(posedge clk) disable iff (rst)
    advance |-> !spent);

  // WRAP is not supported and runs as INCR
  no_wrap_burst_a: assert property (@(posedge clk) disable iff (rst)
    load |-> (burst != BURST_WRAP));

endmodule

/* hdl/axi2axil_pkg.sv */
package axi2axil_pkg;

  // --------------------------------------------------------------------------
  // AXI field types
  // --------------------------------------------------------------------------

  // Beats in a burst minus one
  typedef logic [7:0] burst_len_t;
  // Bytes per beat as a power of two
  typedef logic [2:0] burst_size_t;
  typedef logic [1:0] burst_type_t;
  typedef logic [1:0] resp_t;
  typedef logic [2:0] prot_t;

  // Burst kinds as coded on AxBURST
  localparam burst_type_t BURST_FIXED = 2'd0;
  localparam burst_type_t BURST_INCR  = 2'd1;
  // Only recognized so it can be flagged
  localparam burst_type_t BURST_WRAP  = 2'd2;

  // Response codes, a larger value is the more severe one
  localparam resp_t RESP_OKAY   = 2'd0;
  localparam resp_t RESP_EXOKAY = 2'd1;
  localparam resp_t RESP_SLVERR = 2'd2;
  localparam resp_t RESP_DECERR = 2'd3;

  // --------------------------------------------------------------------------
  // Sequencer states
  // --------------------------------------------------------------------------

  // Write path, one Lite AW/W/B round per beat
  typedef enum logic [2:0] {
    W_IDLE = 3'd0,
    W_ADDR = 3'd1,
    W_DATA = 3'd2,
    W_RESP = 3'd3,
    W_DONE = 3'd4
  } write_state_t;

  // Read path, one Lite AR/R round per beat
  typedef enum logic [1:0] {
    R_IDLE = 2'd0,
    R_ADDR = 2'd1,
    R_DATA = 2'd2
  } read_state_t;

endpackage
